// File: Bender.yml
package:
  name: xcvr_phy_mgmt

sources:
  - include_dirs:
      - design
    files:
      - design/xcvr_csr_pkg.sv
      - design/xcvr_reset_pkg.sv
      - design/xcvr_csr_decode.sv
      - design/xcvr_pcs_csr.sv
      - design/xcvr_reset_seq.sv
      - design/xcvr_mgmt_response.sv
      - design/xcvr_phy_mgmt_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_xcvr_phy_mgmt.sv

// File: all.f
+incdir+design
design/xcvr_csr_pkg.sv
design/xcvr_reset_pkg.sv
design/xcvr_csr_decode.sv
design/xcvr_pcs_csr.sv
design/xcvr_reset_seq.sv
design/xcvr_mgmt_response.sv
design/xcvr_phy_mgmt_top.sv
testbench/tb_xcvr_phy_mgmt.sv

// File: design/xcvr_csr_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module xcvr_csr_decode (
    input  logic                      phy_mgmt_clk,
    input  logic                      embedded_reset,
    input  logic                      read,
    input  logic                      write,
    input  xcvr_csr_pkg::mgmt_addr_t  address,
    input  xcvr_csr_pkg::mgmt_data_t  writedata,
    input  logic                      pll_locked,
    input  xcvr_reset_pkg::lane_vec_t rx_is_lockedtoref,
    input  xcvr_reset_pkg::lane_vec_t rx_is_lockedtodata,
    input  logic                      tx_ready,
    input  logic                      rx_ready,
    output xcvr_csr_pkg::mgmt_data_t  readdata,
    output logic                      reset_all_req,
    output logic                      reset_tx_digital_req,
    output logic                      reset_rx_digital_req,
    output logic                      pll_powerdown_force,
    output xcvr_reset_pkg::lane_vec_t tx_digitalreset_force,
    output xcvr_reset_pkg::lane_vec_t rx_analogreset_force,
    output xcvr_reset_pkg::lane_vec_t rx_digitalreset_force,
    output xcvr_reset_pkg::lane_vec_t phy_loopback_serial,
    output xcvr_reset_pkg::lane_vec_t rx_set_locktoref,
    output xcvr_reset_pkg::lane_vec_t rx_set_locktodata
);
    import xcvr_csr_pkg::*;
    import xcvr_reset_pkg::*;

    logic [2:0] pulse_q;       // all, tx digital, rx digital
    lane_vec_t  wr_lanes;
    mgmt_data_t status_word;

    assign wr_lanes = writedata[`XCVR_LANES-1:0];

    assign reset_all_req        = pulse_q[0];
    assign reset_tx_digital_req = pulse_q[1];
    assign reset_rx_digital_req = pulse_q[2];

    // bit 3 spare with lock status above it
    assign status_word = mgmt_data_t'({rx_is_lockedtoref, rx_is_lockedtodata,
                                       1'b0, pll_locked, rx_ready, tx_ready});

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge phy_mgmt_clk) begin
        if (embedded_reset) begin
            pulse_q               <= '0;
            pll_powerdown_force   <= 1'b0;
            tx_digitalreset_force <= '0;
            rx_analogreset_force  <= '0;
            rx_digitalreset_force <= '0;
            phy_loopback_serial   <= '0;
            rx_set_locktoref      <= '0;
            rx_set_locktodata     <= '0;
        end else begin
            pulse_q <= '0;
            if (write) begin
                case (address)
                    `XCVR_REG_RESET_CTRL: pulse_q <= writedata[2:0];
                    `XCVR_REG_PLL_PD:     pll_powerdown_force   <= writedata[0];
                    `XCVR_REG_TX_DRST:    tx_digitalreset_force <= wr_lanes;
                    `XCVR_REG_RX_ARST:    rx_analogreset_force  <= wr_lanes;
                    `XCVR_REG_RX_DRST:    rx_digitalreset_force <= wr_lanes;
                    `XCVR_REG_LOOPBACK:   phy_loopback_serial   <= wr_lanes; // serial loopback
                    `XCVR_REG_LOCKTOREF:  rx_set_locktoref      <= wr_lanes;
                    `XCVR_REG_LOCKTODATA: rx_set_locktodata     <= wr_lanes;
                    default: ;
                endcase
            end
        end
    end

    // read mux returns all ones outside this map for the AND merge
    always_comb begin
        readdata = '1;
        if (read) begin
            case (address)
                `XCVR_REG_STATUS:     readdata = status_word;
                `XCVR_REG_RESET_CTRL: readdata = '0;
                `XCVR_REG_PLL_PD:     readdata = mgmt_data_t'(pll_powerdown_force);
                `XCVR_REG_TX_DRST:    readdata = mgmt_data_t'(tx_digitalreset_force);
                `XCVR_REG_RX_ARST:    readdata = mgmt_data_t'(rx_analogreset_force);
                `XCVR_REG_RX_DRST:    readdata = mgmt_data_t'(rx_digitalreset_force);
                `XCVR_REG_LOOPBACK:   readdata = mgmt_data_t'(phy_loopback_serial);
                `XCVR_REG_LOCKTOREF:  readdata = mgmt_data_t'(rx_set_locktoref);
                `XCVR_REG_LOCKTODATA: readdata = mgmt_data_t'(rx_set_locktodata);
                default:              readdata = '1;
            endcase
        end
    end

    // the sequencer restarts on every request cycle
    a_pulse_single: assert property (@(posedge phy_mgmt_clk) disable iff (embedded_reset)
        (pulse_q & $past(pulse_q)) == 3'b000);

endmodule

`default_nettype wire

// File: design/xcvr_csr_pkg.sv
`default_nettype none
`include "xcvr_defs.svh"

package xcvr_csr_pkg;

    // register word address on the management bus
    typedef logic [`XCVR_ADDR_WIDTH-1:0] mgmt_addr_t;

    typedef logic [`XCVR_DATA_WIDTH-1:0] mgmt_data_t;   // bus data word

    // bitslip boundaries of all lanes, lane n at [7n+6:7n]
    typedef logic [`XCVR_LANES*`XCVR_BOUNDARY_WIDTH-1:0] boundary_vec_t;

endpackage : xcvr_csr_pkg

`default_nettype wire

// File: design/xcvr_defs.svh
`ifndef XCVR_DEFS_SVH
`define XCVR_DEFS_SVH

// lane and bus geometry
`define XCVR_LANES              4
`define XCVR_BOUNDARY_WIDTH     7
`define XCVR_ADDR_WIDTH         8
`define XCVR_DATA_WIDTH         32

// reset hold times, in phy_mgmt_clk cycles
`define XCVR_T_PLL_POWERDOWN    8
`define XCVR_T_TX_DIGITALRESET  4
`define XCVR_T_RX_ANALOGRESET   4
`define XCVR_T_RX_DIGITALRESET  16

////////////////////////////////////////////////////////////
// common map word addresses
////////////////////////////////////////////////////////////
`define XCVR_REG_STATUS         8'h00   // read only
`define XCVR_REG_RESET_CTRL     8'h01   // pulse bits, reads zero
`define XCVR_REG_PLL_PD         8'h02
`define XCVR_REG_TX_DRST        8'h03
`define XCVR_REG_RX_ARST        8'h04
`define XCVR_REG_RX_DRST        8'h05
`define XCVR_REG_LOOPBACK       8'h06
`define XCVR_REG_LOCKTOREF      8'h07
`define XCVR_REG_LOCKTODATA     8'h08

////////////////////////////////////////////////////////////
// pcs map word addresses
////////////////////////////////////////////////////////////
`define XCVR_REG_PATTERNALIGN   8'h10
`define XCVR_REG_BITSLIP        8'h11
`define XCVR_REG_SYNCSTATUS     8'h12   // read only
`define XCVR_REG_ERRDETECT      8'h13   // sticky, write one to clear

`endif

// File: design/xcvr_mgmt_response.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module xcvr_mgmt_response (
    input  logic                     phy_mgmt_clk,
    input  logic                     embedded_reset,
    input  logic                     read,
    input  xcvr_csr_pkg::mgmt_data_t common_readdata,
    input  xcvr_csr_pkg::mgmt_data_t pcs_readdata,
    output xcvr_csr_pkg::mgmt_data_t readdata,
    output logic                     waitrequest
);
    import xcvr_csr_pkg::*;

    logic       waited;   // current read already stalled once
    mgmt_data_t merged;

    // maps decode disjoint ranges and return all ones elsewhere
    assign merged      = common_readdata & pcs_readdata;
    assign waitrequest = read & ~waited;

    always_ff @(posedge phy_mgmt_clk) begin
        if (embedded_reset)
            waited <= 1'b0;
        else
            waited <= read & ~waited;   // drops with read
    end

    always_ff @(posedge phy_mgmt_clk) begin
        if (waitrequest)
            readdata <= merged;   // captured in the wait cycle
    end

    a_one_wait: assert property (@(posedge phy_mgmt_clk) disable iff (embedded_reset)
        waitrequest |-> read ##1 (read && !waitrequest));

endmodule

`default_nettype wire

// File: design/xcvr_pcs_csr.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module xcvr_pcs_csr (
    input  logic                        phy_mgmt_clk,
    input  logic                        embedded_reset,
    input  logic                        read,
    input  logic                        write,
    input  xcvr_csr_pkg::mgmt_addr_t    address,
    input  xcvr_csr_pkg::mgmt_data_t    writedata,
    input  xcvr_reset_pkg::lane_vec_t   rx_syncstatus,
    input  xcvr_reset_pkg::lane_vec_t   rx_errdetect,
    output xcvr_csr_pkg::mgmt_data_t    readdata,
    output xcvr_reset_pkg::lane_vec_t   rx_enapatternalign,
    output xcvr_csr_pkg::boundary_vec_t tx_bitslipboundaryselect
);
    import xcvr_csr_pkg::*;
    import xcvr_reset_pkg::*;

    lane_vec_t syncstatus_q;
    lane_vec_t errdetect_q;    // sticky per lane
    lane_vec_t err_clr;

    assign err_clr = (write && address == `XCVR_REG_ERRDETECT) ?
                     writedata[`XCVR_LANES-1:0] : '0;

    always_ff @(posedge phy_mgmt_clk) begin
        syncstatus_q <= rx_syncstatus;   // sampled every cycle
    end

    always_ff @(posedge phy_mgmt_clk) begin
        if (embedded_reset) begin
            rx_enapatternalign       <= '0;
            tx_bitslipboundaryselect <= '0;
            errdetect_q              <= '0;
        end else begin
            // new error beats a clear in the same cycle
            errdetect_q <= (errdetect_q & ~err_clr) | rx_errdetect;
            if (write && address == `XCVR_REG_PATTERNALIGN)
                rx_enapatternalign <= writedata[`XCVR_LANES-1:0];
            if (write && address == `XCVR_REG_BITSLIP)
                tx_bitslipboundaryselect <= writedata[$bits(boundary_vec_t)-1:0];
        end
    end

    always_comb begin
        readdata = '1;   // not decoded here
        if (read) begin
            case (address)
                `XCVR_REG_PATTERNALIGN: readdata = mgmt_data_t'(rx_enapatternalign);
                `XCVR_REG_BITSLIP:      readdata = mgmt_data_t'(tx_bitslipboundaryselect);
                `XCVR_REG_SYNCSTATUS:   readdata = mgmt_data_t'(syncstatus_q);
                `XCVR_REG_ERRDETECT:    readdata = mgmt_data_t'(errdetect_q);
                default:                readdata = '1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/xcvr_phy_mgmt_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module xcvr_phy_mgmt_top (
    input  logic                        phy_mgmt_clk,
    input  logic                        embedded_reset,
    input  logic                        phy_mgmt_read,
    input  logic                        phy_mgmt_write,
    input  xcvr_csr_pkg::mgmt_addr_t    phy_mgmt_address,
    input  xcvr_csr_pkg::mgmt_data_t    phy_mgmt_writedata,
    output xcvr_csr_pkg::mgmt_data_t    phy_mgmt_readdata,
    output logic                        phy_mgmt_waitrequest,
    input  logic                        pll_locked,
    input  xcvr_reset_pkg::lane_vec_t   rx_is_lockedtoref,
    input  xcvr_reset_pkg::lane_vec_t   rx_is_lockedtodata,
    input  xcvr_reset_pkg::lane_vec_t   rx_syncstatus,
    input  xcvr_reset_pkg::lane_vec_t   rx_errdetect,
    output logic                        pll_powerdown,
    output xcvr_reset_pkg::lane_vec_t   tx_digitalreset,
    output xcvr_reset_pkg::lane_vec_t   rx_analogreset,
    output xcvr_reset_pkg::lane_vec_t   rx_digitalreset,
    output logic                        tx_ready,
    output logic                        rx_ready,
    output xcvr_reset_pkg::lane_vec_t   phy_loopback_serial,
    output xcvr_reset_pkg::lane_vec_t   rx_set_locktoref,
    output xcvr_reset_pkg::lane_vec_t   rx_set_locktodata,
    output xcvr_reset_pkg::lane_vec_t   rx_enapatternalign,
    output xcvr_csr_pkg::boundary_vec_t tx_bitslipboundaryselect
);
    import xcvr_csr_pkg::*;
    import xcvr_reset_pkg::*;

    mgmt_data_t common_readdata;
    mgmt_data_t pcs_readdata;

    // csr requests and forces into the sequencer
    logic       reset_all_req;
    logic       reset_tx_digital_req;
    logic       reset_rx_digital_req;
    logic       pll_powerdown_force;
    lane_vec_t  tx_digitalreset_force;
    lane_vec_t  rx_analogreset_force;
    lane_vec_t  rx_digitalreset_force;

    xcvr_csr_decode csr_decode_i (
        .read      (phy_mgmt_read),
        .write     (phy_mgmt_write),
        .address   (phy_mgmt_address),
        .writedata (phy_mgmt_writedata),
        .readdata  (common_readdata),
        .*
    );

    xcvr_pcs_csr pcs_csr_i (
        .read      (phy_mgmt_read),
        .write     (phy_mgmt_write),
        .address   (phy_mgmt_address),
        .writedata (phy_mgmt_writedata),
        .readdata  (pcs_readdata),
        .*
    );

    xcvr_reset_seq reset_seq_i (.*);   // tx_ready, rx_ready back into status

    xcvr_mgmt_response response_i (
        .read        (phy_mgmt_read),
        .readdata    (phy_mgmt_readdata),
        .waitrequest (phy_mgmt_waitrequest),
        .*
    );

endmodule

`default_nettype wire

// File: design/xcvr_reset_pkg.sv
`default_nettype none
`include "xcvr_defs.svh"

package xcvr_reset_pkg;

    typedef logic [`XCVR_LANES-1:0] lane_vec_t;   // one bit per lane

    // tx chain, pll first then pcs
    typedef enum logic [1:0] {
        TX_PLL_PD,
        TX_WAIT_LOCK,
        TX_DIG_RST,
        TX_READY
    } tx_rst_state_t;

    typedef enum logic [1:0] {
        RX_ANA_RST,
        RX_WAIT_LOCK,   // cdr lock to data on all lanes
        RX_DIG_RST,
        RX_READY
    } rx_rst_state_t;

    typedef logic [4:0] rst_count_t;   // covers the longest hold

endpackage : xcvr_reset_pkg

`default_nettype wire

// File: design/xcvr_reset_seq.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module xcvr_reset_seq (
    input  logic                      phy_mgmt_clk,
    input  logic                      embedded_reset,
    input  logic                      pll_locked,
    input  xcvr_reset_pkg::lane_vec_t rx_is_lockedtodata,
    input  logic                      reset_all_req,
    input  logic                      reset_tx_digital_req,
    input  logic                      reset_rx_digital_req,
    input  logic                      pll_powerdown_force,
    input  xcvr_reset_pkg::lane_vec_t tx_digitalreset_force,
    input  xcvr_reset_pkg::lane_vec_t rx_analogreset_force,
    input  xcvr_reset_pkg::lane_vec_t rx_digitalreset_force,
    output logic                      pll_powerdown,
    output xcvr_reset_pkg::lane_vec_t tx_digitalreset,
    output xcvr_reset_pkg::lane_vec_t rx_analogreset,
    output xcvr_reset_pkg::lane_vec_t rx_digitalreset,
    output logic                      tx_ready,
    output logic                      rx_ready
);
    import xcvr_reset_pkg::*;

    tx_rst_state_t tx_state, tx_next;
    rx_rst_state_t rx_state, rx_next;
    rst_count_t    tx_cnt, tx_cnt_next;
    rst_count_t    rx_cnt, rx_cnt_next;
    logic          rx_locked;

    assign rx_locked = &rx_is_lockedtodata;   // every lane on data

    ////////////////////////////////////////////////////////////
    // tx chain
    ////////////////////////////////////////////////////////////
    always_comb begin
        tx_next     = tx_state;
        tx_cnt_next = '0;
        if (reset_all_req) begin
            tx_next = TX_PLL_PD;
        end else begin
            case (tx_state)
                TX_PLL_PD: begin
                    if (tx_cnt == rst_count_t'(`XCVR_T_PLL_POWERDOWN - 1))
                        tx_next = TX_WAIT_LOCK;
                    else
                        tx_cnt_next = tx_cnt + 1'b1;
                end
                TX_WAIT_LOCK: begin
                    if (pll_locked)
                        tx_next = TX_DIG_RST;
                end
                TX_DIG_RST: begin
                    if (!pll_locked)
                        tx_next = TX_WAIT_LOCK;
                    else if (reset_tx_digital_req)
                        tx_cnt_next = '0;   // restart the hold
                    else if (tx_cnt == rst_count_t'(`XCVR_T_TX_DIGITALRESET - 1))
                        tx_next = TX_READY;
                    else
                        tx_cnt_next = tx_cnt + 1'b1;
                end
                default: begin
                    if (!pll_locked)
                        tx_next = TX_WAIT_LOCK;
                    else if (reset_tx_digital_req)
                        tx_next = TX_DIG_RST;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // rx chain
    ////////////////////////////////////////////////////////////
    always_comb begin
        rx_next     = rx_state;
        rx_cnt_next = '0;
        if (reset_all_req) begin
            rx_next = RX_ANA_RST;
        end else begin
            case (rx_state)
                RX_ANA_RST: begin
                    if (rx_cnt == rst_count_t'(`XCVR_T_RX_ANALOGRESET - 1))
                        rx_next = RX_WAIT_LOCK;
                    else
                        rx_cnt_next = rx_cnt + 1'b1;
                end
                RX_WAIT_LOCK: begin
                    if (rx_locked)
                        rx_next = RX_DIG_RST;
                end
                RX_DIG_RST: begin
                    if (!rx_locked)
                        rx_next = RX_WAIT_LOCK;
                    else if (reset_rx_digital_req)
                        rx_cnt_next = '0;
                    else if (rx_cnt == rst_count_t'(`XCVR_T_RX_DIGITALRESET - 1))
                        rx_next = RX_READY;
                    else
                        rx_cnt_next = rx_cnt + 1'b1;
                end
                default: begin
                    if (!rx_locked)
                        rx_next = RX_WAIT_LOCK;
                    else if (reset_rx_digital_req)
                        rx_next = RX_DIG_RST;
                end
            endcase
        end
    end

    // outputs follow next state, csr forces OR'd in
    always_ff @(posedge phy_mgmt_clk) begin
        if (embedded_reset) begin
            tx_state        <= TX_PLL_PD;
            rx_state        <= RX_ANA_RST;
            tx_cnt          <= '0;
            rx_cnt          <= '0;
            pll_powerdown   <= 1'b1;
            tx_digitalreset <= '1;
            rx_analogreset  <= '1;
            rx_digitalreset <= '1;
            tx_ready        <= 1'b0;
            rx_ready        <= 1'b0;
        end else begin
            tx_state        <= tx_next;
            rx_state        <= rx_next;
            tx_cnt          <= tx_cnt_next;
            rx_cnt          <= rx_cnt_next;
            pll_powerdown   <= (tx_next == TX_PLL_PD) | pll_powerdown_force;
            tx_digitalreset <= {`XCVR_LANES{tx_next != TX_READY}} | tx_digitalreset_force;
            rx_analogreset  <= {`XCVR_LANES{rx_next == RX_ANA_RST}} | rx_analogreset_force;
            rx_digitalreset <= {`XCVR_LANES{rx_next != RX_READY}} | rx_digitalreset_force;
            tx_ready        <= (tx_next == TX_READY);
            rx_ready        <= (rx_next == RX_READY);
        end
    end

    a_tx_ready_clean: assert property (@(posedge phy_mgmt_clk) disable iff (embedded_reset)
        tx_ready |-> (tx_digitalreset & ~$past(tx_digitalreset_force)) == '0);

    // rx cannot finish ahead of a pll powerdown from reset_all
    a_rx_ready_pll_up: assert property (@(posedge phy_mgmt_clk) disable iff (embedded_reset)
        rx_ready |-> (!pll_powerdown || $past(pll_powerdown_force)));

endmodule

`default_nettype wire

// File: testbench/tb_xcvr_phy_mgmt.sv
`timescale 1ns/10ps
`default_nettype none
`include "xcvr_defs.svh"

module tb_xcvr_phy_mgmt;
    import xcvr_csr_pkg::*;
    import xcvr_reset_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_ROWS       = 33;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,       // read and compare under mask
        OP_WAIT,       // wait for ready flags
        OP_ERR_PULSE,
        OP_LOCK_MASK,  // lanes allowed to lock to data
        OP_RAND,       // random write and readback, then restore zero
        OP_WR_OUT      // write, then check the output one cycle later
    } op_t;

    typedef struct packed {
        op_t        op;
        mgmt_addr_t addr;
        mgmt_data_t data;   // OP_WAIT uses it as minimum powerdown run
        mgmt_data_t exp;
        mgmt_data_t mask;
    } row_t;

    logic          phy_mgmt_clk;
    logic          embedded_reset;
    logic          phy_mgmt_read;
    logic          phy_mgmt_write;
    mgmt_addr_t    phy_mgmt_address;
    mgmt_data_t    phy_mgmt_writedata;
    mgmt_data_t    phy_mgmt_readdata;
    logic          phy_mgmt_waitrequest;
    logic          pll_locked;
    lane_vec_t     rx_is_lockedtoref;
    lane_vec_t     rx_is_lockedtodata;
    lane_vec_t     rx_syncstatus;
    lane_vec_t     rx_errdetect;
    logic          pll_powerdown;
    lane_vec_t     tx_digitalreset;
    lane_vec_t     rx_analogreset;
    lane_vec_t     rx_digitalreset;
    logic          tx_ready;
    logic          rx_ready;
    lane_vec_t     phy_loopback_serial;
    lane_vec_t     rx_set_locktoref;
    lane_vec_t     rx_set_locktodata;
    lane_vec_t     rx_enapatternalign;
    boundary_vec_t tx_bitslipboundaryselect;

    logic          rx_lock_model;
    lane_vec_t     rx_lock_mask;
    int            pll_cnt;
    int            rx_cnt;
    int            pd_run;        // current pll_powerdown high run
    int            pd_last_run;
    integer        seed;
    row_t          rows [NUM_ROWS];
    int            n_rows;

    assign rx_is_lockedtodata = {`XCVR_LANES{rx_lock_model}} & rx_lock_mask;

    xcvr_phy_mgmt_top dut_i (.*);

    always #2 phy_mgmt_clk = ~phy_mgmt_clk;

    ////////////////////////////////////////////////////////////
    // pll and cdr lock models
    ////////////////////////////////////////////////////////////
    always begin
        @(posedge phy_mgmt_clk);
        #0.5;
        if (pll_powerdown === 1'b1) begin
            pll_cnt = 0;
            pd_run  = pd_run + 1;
        end else begin
            if (pd_run != 0)
                pd_last_run = pd_run;
            pd_run = 0;
            if (pll_cnt < 3)
                pll_cnt = pll_cnt + 1;
        end
        pll_locked = (pll_cnt >= 3);   // 3 cycles after powerdown falls
        if (|rx_analogreset !== 1'b0)
            rx_cnt = 0;
        else if (rx_cnt < 5)
            rx_cnt = rx_cnt + 1;
        rx_lock_model = (rx_cnt >= 5);
    end

    task automatic next_cycle;
        @(posedge phy_mgmt_clk);
        #0.5;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic bus_write(input mgmt_addr_t addr, input mgmt_data_t data);
        phy_mgmt_write     = 1'b1;
        phy_mgmt_address   = addr;
        phy_mgmt_writedata = data;
        next_cycle();
        phy_mgmt_write = 1'b0;
    endtask

    task automatic bus_read(input mgmt_addr_t addr, output mgmt_data_t data);
        int waits;
        waits = 0;
        phy_mgmt_read    = 1'b1;
        phy_mgmt_address = addr;
        #1;   // mid cycle where waitrequest has settled
        while (phy_mgmt_waitrequest) begin
            waits++;
            if (waits > TIMEOUT_CYCLES)
                report_timeout("waitrequest to fall");
            @(posedge phy_mgmt_clk);
            #1.5;
        end
        data = phy_mgmt_readdata;
        check_value("read wait cycles", 1, waits);
        next_cycle();   // read completes at this edge
        phy_mgmt_read = 1'b0;
        next_cycle();   // idle cycle between reads
    endtask

    task automatic wait_ready(input logic [1:0] mask, input logic [1:0] target);
        int n;
        n = 0;
        while (({rx_ready, tx_ready} & mask) !== target) begin
            n++;
            if (n > TIMEOUT_CYCLES)
                report_timeout("tx_ready and rx_ready");
            next_cycle();
        end
    endtask

    // registers with an output of their own
    task automatic check_reg_output(input mgmt_addr_t addr, input mgmt_data_t expected);
        case (addr)
            `XCVR_REG_LOOPBACK:     check_value("phy_loopback_serial", expected, phy_loopback_serial);
            `XCVR_REG_LOCKTOREF:    check_value("rx_set_locktoref", expected, rx_set_locktoref);
            `XCVR_REG_LOCKTODATA:   check_value("rx_set_locktodata", expected, rx_set_locktodata);
            `XCVR_REG_PATTERNALIGN: check_value("rx_enapatternalign", expected, rx_enapatternalign);
            `XCVR_REG_BITSLIP:
                check_value("tx_bitslipboundaryselect", expected, tx_bitslipboundaryselect);
            `XCVR_REG_TX_DRST:      check_value("tx_digitalreset", expected, tx_digitalreset);
            default: ;
        endcase
    endtask

    task automatic run_row(input row_t r);
        mgmt_data_t rdata;
        mgmt_data_t rnd;
        case (r.op)
            OP_WRITE: bus_write(r.addr, r.data);
            OP_READ: begin
                bus_read(r.addr, rdata);
                check_value($sformatf("readdata[0x%02h]", r.addr), r.exp & r.mask, rdata & r.mask);
            end
            OP_WAIT: begin
                wait_ready(r.mask[1:0], r.exp[1:0]);
                if (r.mask[0] && r.exp[0])
                    check_value("tx_digitalreset", 0, tx_digitalreset);
                if (r.data != 0 && pd_last_run < r.data)
                    check_value("pll_powerdown high cycles", r.data, pd_last_run);
            end
            OP_ERR_PULSE: begin
                rx_errdetect = r.data[`XCVR_LANES-1:0];
                next_cycle();
                rx_errdetect = '0;
            end
            OP_LOCK_MASK: begin
                rx_lock_mask = r.data[`XCVR_LANES-1:0];
                next_cycle();
            end
            OP_RAND: begin
                rnd = $random(seed);
                bus_write(r.addr, rnd);
                bus_read(r.addr, rdata);
                check_value($sformatf("readdata[0x%02h]", r.addr), rnd & r.mask, rdata);
                check_reg_output(r.addr, rnd & r.mask);
                bus_write(r.addr, '0);
            end
            default: begin   // OP_WR_OUT
                bus_write(r.addr, r.data);
                next_cycle();
                check_reg_output(r.addr, r.exp);
                check_value("tx_ready", 1, tx_ready);
            end
        endcase
    endtask

    task automatic add_row(input op_t op, input mgmt_addr_t addr, input mgmt_data_t data,
                           input mgmt_data_t exp, input mgmt_data_t mask);
        rows[n_rows] = '{op, addr, data, exp, mask};
        n_rows++;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    task automatic build_table;
        add_row(OP_READ, `XCVR_REG_STATUS, 0, 32'h0, 32'h3);
        add_row(OP_WAIT, 0, `XCVR_T_PLL_POWERDOWN, 32'h1, 32'h1);   // tx first
        add_row(OP_WAIT, 0, 0, 32'h3, 32'h3);
        add_row(OP_READ, `XCVR_REG_STATUS, 0, 32'h6f7, 32'hff7);
        add_row(OP_LOCK_MASK, 0, 32'hb, 0, 0);                      // lane 2 loses data lock
        add_row(OP_WAIT, 0, 0, 32'h0, 32'h2);
        add_row(OP_LOCK_MASK, 0, 32'hf, 0, 0);
        add_row(OP_WAIT, 0, 0, 32'h3, 32'h3);
        add_row(OP_RAND, `XCVR_REG_LOOPBACK, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_LOCKTOREF, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_LOCKTODATA, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_PATTERNALIGN, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_BITSLIP, 0, 0, 32'h0fff_ffff);
        add_row(OP_RAND, `XCVR_REG_TX_DRST, 0, 0, 32'hf);           // while tx still ready
        add_row(OP_RAND, `XCVR_REG_RX_DRST, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_RX_ARST, 0, 0, 32'hf);
        add_row(OP_RAND, `XCVR_REG_PLL_PD, 0, 0, 32'h1);
        add_row(OP_READ, `XCVR_REG_RESET_CTRL, 0, 32'h0, 32'hffff_ffff);
        add_row(OP_READ, 8'h30, 0, 32'hffff_ffff, 32'hffff_ffff);
        add_row(OP_WAIT, 0, 0, 32'h3, 32'h3);
        add_row(OP_WR_OUT, `XCVR_REG_TX_DRST, 32'h5, 32'h5, 0);
        add_row(OP_WRITE, `XCVR_REG_TX_DRST, 32'h0, 0, 0);
        add_row(OP_WRITE, `XCVR_REG_RESET_CTRL, 32'h2, 0, 0);      // tx digital pulse
        add_row(OP_WAIT, 0, 0, 32'h0, 32'h1);
        add_row(OP_WAIT, 0, 0, 32'h3, 32'h3);
        add_row(OP_WRITE, `XCVR_REG_RESET_CTRL, 32'h1, 0, 0);      // reset all
        add_row(OP_WAIT, 0, 0, 32'h0, 32'h3);
        add_row(OP_WAIT, 0, `XCVR_T_PLL_POWERDOWN, 32'h3, 32'h3);
        add_row(OP_READ, `XCVR_REG_SYNCSTATUS, 0, 32'h9, 32'hf);
        add_row(OP_ERR_PULSE, 0, 32'h4, 0, 0);
        add_row(OP_READ, `XCVR_REG_ERRDETECT, 0, 32'h4, 32'hffff_ffff);
        add_row(OP_WRITE, `XCVR_REG_ERRDETECT, 32'h4, 0, 0);
        add_row(OP_READ, `XCVR_REG_ERRDETECT, 0, 32'h0, 32'hffff_ffff);
    endtask

    initial begin
        seed               = 63;
        n_rows             = 0;
        phy_mgmt_clk       = 1'b0;
        embedded_reset     = 1'b1;
        phy_mgmt_read      = 1'b0;
        phy_mgmt_write     = 1'b0;
        phy_mgmt_address   = '0;
        phy_mgmt_writedata = '0;
        pll_locked         = 1'b0;
        rx_is_lockedtoref  = 4'h6;
        rx_syncstatus      = 4'h9;
        rx_errdetect       = '0;
        rx_lock_model      = 1'b0;
        rx_lock_mask       = '1;
        pll_cnt            = 0;
        rx_cnt             = 0;
        pd_run             = 0;
        pd_last_run        = 0;
        build_table();

        repeat (4) next_cycle();
        // values held while reset is still asserted
        check_value("pll_powerdown", 1, pll_powerdown);
        check_value("tx_digitalreset", 32'hf, tx_digitalreset);
        check_value("rx_analogreset", 32'hf, rx_analogreset);
        check_value("rx_digitalreset", 32'hf, rx_digitalreset);
        check_value("tx_ready", 0, tx_ready);
        check_value("rx_ready", 0, rx_ready);
        check_value("phy_mgmt_waitrequest", 0, phy_mgmt_waitrequest);
        check_value("rx_enapatternalign", 0, rx_enapatternalign);
        embedded_reset = 1'b0;

        for (int i = 0; i < n_rows; i++)
            run_row(rows[i]);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
